/* tora_video_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen geometry and ROM address widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TORA_VIDEO_MACROS_SVH
`define TORA_VIDEO_MACROS_SVH

// Horizontal timing in pixels
`define TORA_H_TOTAL   384
`define TORA_H_ACTIVE  256

// Vertical timing in lines
`define TORA_V_TOTAL   262
`define TORA_V_ACTIVE  224

// Pixel enables from counter position to colour output
`define TORA_PIPE_DLY  3

// External ROM address widths
`define TORA_MAP_AW    12
`define TORA_SCR_AW    14

`endif

/* tora_video_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packed structs for the tilemap video path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tora_video_pkg;

    // Screen position and blanking levels
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        logic       lhbl;
        logic       lvbl;
        logic       hinit;
    } vid_pos_t;

    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
    } scr_pos_t;

    // One map ROM word
    typedef struct packed {
        logic       vflip;
        logic       hflip;
        logic [3:0] pal;
        logic [9:0] code;
    } map_attr_t;

    // Eight 4-bit pixels, pixel k at pixels[4k+3:4k]
    typedef struct packed {
        logic        hflip;
        logic [3:0]  pal;
        logic [31:0] pixels;
    } tile_row_t;

    // pix of 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pix;
    } layer_pxl_t;

    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [11:0] data;
    } pal_wr_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

/* tora_vtimer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel and line counters with blanking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module tora_vtimer (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                cen6,
    output tora_video_pkg::vid_pos_t pos
);

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       h_last;
    logic       v_last;

    assign h_last = (hcnt == 9'(`TORA_H_TOTAL - 1));
    assign v_last = (vcnt == 9'(`TORA_V_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (cen6) begin
            if (h_last) begin
                hcnt <= '0;
                // Line advances with the horizontal wrap
                if (v_last) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 9'd1;
                end
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    // Levels follow the counters directly
    always_comb begin
        pos.h     = hcnt;
        pos.v     = vcnt;
        pos.lhbl  = (hcnt < 9'(`TORA_H_ACTIVE));
        pos.lvbl  = (vcnt < 9'(`TORA_V_ACTIVE));
        // Lasts one pixel period, 16 pixels before the line ends
        pos.hinit = (hcnt == 9'(`TORA_H_TOTAL - 16));
    end

endmodule

`default_nettype wire

/* tora_tile_fetch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Map and graphics ROM fetch FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module tora_tile_fetch (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      cen6,
    input  wire tora_video_pkg::vid_pos_t  pos,
    input  wire tora_video_pkg::scr_pos_t  scrpos,
    output logic [`TORA_MAP_AW-1:0]        map_addr,
    input  wire tora_video_pkg::map_attr_t map_data,
    output logic [`TORA_SCR_AW-1:0]        scr_addr,
    output logic                           scr_req,
    input  wire logic [15:0]               scr_data,
    input  wire logic                      scr_ok,
    output tora_video_pkg::tile_row_t      row,
    output logic                           load
);
    import tora_video_pkg::*;

    typedef enum logic [2:0] {IDLE, MAP, ROM0, ROM1, HOLD} state_t;

    state_t     state;
    scr_pos_t   scr_lat;
    logic [8:0] hx;
    logic [8:0] vline;
    logic [8:0] px;
    logic [8:0] py;
    logic [8:0] col_px;
    logic [2:0] tile_row;
    logic       win_start;
    logic       win_end;

    // In blanking H counts as H - H_TOTAL so the last window prefetches pixel 0
    always_comb begin
        hx = pos.lhbl ? pos.h : pos.h + 9'(512 - `TORA_H_TOTAL);
        if (pos.lhbl) begin
            vline = pos.v;
        end else if (pos.v == 9'(`TORA_V_TOTAL - 1)) begin
            vline = '0;
        end else begin
            vline = pos.v + 9'd1;
        end
        px     = hx + scr_lat.h;
        py     = vline + scr_lat.v;
        col_px = px + 9'd8;
    end

    assign win_start = cen6 && (px[2:0] == 3'd0);
    assign win_end   = cen6 && (px[2:0] == 3'd7);
    assign load      = (state == HOLD) && win_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scr_lat  <= '0;
            map_addr <= '0;
            scr_addr <= '0;
            scr_req  <= 1'b0;
            state    <= IDLE;
        end else begin
            scr_req  <= 1'b0;
            // Stays on the window address, so map_data is ready by MAP
            map_addr <= {py[8:3], col_px[8:3]};
            if (cen6 && pos.hinit) begin
                // New scroll may shift the window phase, restart cleanly
                scr_lat <= scrpos;
                state   <= IDLE;
            end else begin
                case (state)
                    IDLE: if (win_start) state <= MAP;
                    MAP: begin
                        scr_addr <= {map_data.code, tile_row ^ {3{map_data.vflip}}, 1'b0};
                        scr_req  <= 1'b1;
                        state    <= ROM0;
                    end
                    ROM0: if (scr_ok) begin
                        scr_addr[0] <= 1'b1;
                        scr_req     <= 1'b1;
                        state       <= ROM1;
                    end
                    ROM1: if (scr_ok) state <= HOLD;
                    HOLD: if (win_end) state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Row data collected across the window
    always_ff @(posedge clk) begin
        if (state == IDLE && win_start) tile_row <= py[2:0];
        if (state == MAP) begin
            row.hflip <= map_data.hflip;
            row.pal   <= map_data.pal;
        end
        if (state == ROM0 && scr_ok) row.pixels[15:0]  <= scr_data;
        if (state == ROM1 && scr_ok) row.pixels[31:16] <= scr_data;
    end

endmodule

`default_nettype wire

/* tora_tile_shifter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile row serializer with h-flip
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tora_tile_shifter (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      cen6,
    input  wire tora_video_pkg::tile_row_t row,
    input  wire logic                      load,
    output tora_video_pkg::layer_pxl_t     pxl
);

    logic [31:0] pix_buf;
    logic [3:0]  pal_buf;
    logic        hflip_buf;
    logic [2:0]  cnt;
    logic [2:0]  sel;

    // Mirror the pixel order for flipped tiles
    assign sel = hflip_buf ? ~cnt : cnt;

    always_ff @(posedge clk) begin
        if (load) begin
            pix_buf   <= row.pixels;
            pal_buf   <= row.pal;
            hflip_buf <= row.hflip;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            pxl <= '0;
        end else begin
            // Load lands on the enable that shows pixel 7 of the old row
            if (load) begin
                cnt <= '0;
            end else if (cen6) begin
                cnt <= cnt + 3'd1;
            end
            if (cen6) begin
                pxl.pal <= pal_buf;
                pxl.pix <= pix_buf[{sel, 2'b00} +: 4];
            end
        end
    end

endmodule

`default_nettype wire

/* tora_colmix.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Palette lookup, blanking and colour output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module tora_colmix (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       cen6,
    input  wire tora_video_pkg::vid_pos_t   pos,
    input  wire tora_video_pkg::layer_pxl_t pxl,
    input  wire logic                       gfx_en,
    input  wire tora_video_pkg::pal_wr_t    pal_wr,
    output tora_video_pkg::rgb_t            rgb,
    output logic                            LHBL_dly,
    output logic                            LVBL_dly
);
    import tora_video_pkg::*;

    // Output register makes up the last stage
    localparam int BLK_DLY = `TORA_PIPE_DLY - 1;

    logic [11:0]        pal_ram [0:255];
    logic [11:0]        pal_dout;
    logic [7:0]         rd_idx;
    logic [BLK_DLY-1:0] hbl_sr;
    logic [BLK_DLY-1:0] vbl_sr;
    logic               blank_ok;

    // Transparent or disabled layer shows the backdrop
    assign rd_idx   = (gfx_en && pxl.pix != 4'd0) ? {pxl.pal, pxl.pix} : 8'd0;
    assign blank_ok = hbl_sr[BLK_DLY-1] & vbl_sr[BLK_DLY-1];

    // CPU write port
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
    end

    // Pixel read port
    always_ff @(posedge clk) begin
        if (cen6) begin
            pal_dout <= pal_ram[rd_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbl_sr   <= '0;
            vbl_sr   <= '0;
            rgb      <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (cen6) begin
            hbl_sr   <= {hbl_sr[BLK_DLY-2:0], pos.lhbl};
            vbl_sr   <= {vbl_sr[BLK_DLY-2:0], pos.lvbl};
            // Black outside the visible area
            rgb      <= blank_ok ? rgb_t'(pal_dout) : '0;
            LHBL_dly <= hbl_sr[BLK_DLY-1];
            LVBL_dly <= vbl_sr[BLK_DLY-1];
        end
    end

endmodule

`default_nettype wire

/* tora_video.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scroll layer video top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module tora_video (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      cen6,
    input  wire tora_video_pkg::scr_pos_t  scrpos,
    input  wire logic                      gfx_en,
    input  wire tora_video_pkg::pal_wr_t   pal_wr,
    // Map ROM
    output wire logic [`TORA_MAP_AW-1:0]   map_addr,
    input  wire tora_video_pkg::map_attr_t map_data,
    // Graphics ROM
    output wire logic [`TORA_SCR_AW-1:0]   scr_addr,
    output wire logic                      scr_req,
    input  wire logic [15:0]               scr_data,
    input  wire logic                      scr_ok,
    // Pixel output
    output wire logic [3:0]                red,
    output wire logic [3:0]                green,
    output wire logic [3:0]                blue,
    output wire logic                      LHBL_dly,
    output wire logic                      LVBL_dly
);
    import tora_video_pkg::*;

    wire vid_pos_t   pos;
    wire tile_row_t  row;
    wire logic       load;
    wire layer_pxl_t pxl;
    wire rgb_t       rgb;

    tora_vtimer u_vtimer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .pos      ( pos      )
    );

    tora_tile_fetch u_fetch (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .pos      ( pos      ),
        .scrpos   ( scrpos   ),
        .map_addr ( map_addr ),
        .map_data ( map_data ),
        .scr_addr ( scr_addr ),
        .scr_req  ( scr_req  ),
        .scr_data ( scr_data ),
        .scr_ok   ( scr_ok   ),
        .row      ( row      ),
        .load     ( load     )
    );

    tora_tile_shifter u_shifter (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .row      ( row      ),
        .load     ( load     ),
        .pxl      ( pxl      )
    );

    tora_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .pos      ( pos      ),
        .pxl      ( pxl      ),
        .gfx_en   ( gfx_en   ),
        .pal_wr   ( pal_wr   ),
        .rgb      ( rgb      ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

`default_nettype wire

/* tb_tora_rom_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Map ROM and graphics ROM models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module map_rom_model (
    input  wire logic                   clk,
    input  wire logic [`TORA_MAP_AW-1:0] addr,
    output tora_video_pkg::map_attr_t  data
);

    function automatic logic [15:0] map_word(input logic [`TORA_MAP_AW-1:0] a);
        logic [15:0] x;
        x = {4'd0, a} * 16'd40503 + 16'h3c5a;
        return x ^ (x >> 7);
    endfunction

    initial data = '0;

    // One clk of read latency
    always @(posedge clk) begin
        data <= map_word(addr);
    end

endmodule

module gfx_rom_model (
    input  wire logic                   clk,
    input  wire logic [`TORA_SCR_AW-1:0] addr,
    input  wire logic                   req,
    output logic [15:0]                 data,
    output logic                        ok
);

    logic [2:0]              wait_cnt;
    logic [`TORA_SCR_AW-1:0] addr_q;
    int unsigned             lat;

    function automatic logic [15:0] gfx_word(input logic [`TORA_SCR_AW-1:0] a);
        logic [15:0] x;
        x = {2'd0, a} * 16'd25173 + 16'd13849;
        return x ^ (x >> 5);
    endfunction

    initial begin
        data     = '0;
        ok       = 1'b0;
        wait_cnt = '0;
        addr_q   = '0;
    end

    // Answer 1 to 6 clk after the request
    always @(posedge clk) begin
        ok <= 1'b0;
        if (req) begin
            lat = ($urandom % 6) + 1;
            addr_q <= addr;
            if (lat == 1) begin
                ok   <= 1'b1;
                data <= gfx_word(addr);
            end else begin
                wait_cnt <= 3'(lat - 1);
            end
        end else if (wait_cnt != 0) begin
            wait_cnt <= wait_cnt - 3'd1;
            if (wait_cnt == 3'd1) begin
                ok   <= 1'b1;
                data <= gfx_word(addr_q);
            end
        end
    end

endmodule

`default_nettype wire

/* tb_tora_video.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tilemap video testbench with reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "tora_video_macros.svh"

module tb_tora_video;
    import tora_video_pkg::*;

    localparam int H_TOTAL   = `TORA_H_TOTAL;
    localparam int H_ACTIVE  = `TORA_H_ACTIVE;
    localparam int V_TOTAL   = `TORA_V_TOTAL;
    localparam int V_ACTIVE  = `TORA_V_ACTIVE;
    localparam int PIPE_DLY  = `TORA_PIPE_DLY;
    // One frame covers the wait for vblank, plus the lines of the other tests
    localparam int RUN_LINES = V_TOTAL + 32;
    localparam int WDOG_TIME = RUN_LINES * H_TOTAL * 8 * 4 + 4096;

    logic                    clk;
    logic                    rst_n;
    logic                    cen6;
    logic                    gfx_en;
    scr_pos_t                scrpos;
    pal_wr_t                 pal_wr;
    logic [`TORA_MAP_AW-1:0] map_addr;
    map_attr_t               map_data;
    logic [`TORA_SCR_AW-1:0] scr_addr;
    logic                    scr_req;
    logic [15:0]             scr_data;
    logic                    scr_ok;
    logic [3:0]              red;
    logic [3:0]              green;
    logic [3:0]              blue;
    logic                    LHBL_dly;
    logic                    LVBL_dly;

    logic [2:0]  cen_div;
    logic [11:0] pal_ref [0:255];
    logic [8:0]  ref_sh;
    logic [8:0]  ref_sv;
    int          scan_h;
    int          scan_v;
    int          chk_cnt;
    int          err_cnt;

    tora_video i_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .scrpos   ( scrpos   ),
        .gfx_en   ( gfx_en   ),
        .pal_wr   ( pal_wr   ),
        .map_addr ( map_addr ),
        .map_data ( map_data ),
        .scr_addr ( scr_addr ),
        .scr_req  ( scr_req  ),
        .scr_data ( scr_data ),
        .scr_ok   ( scr_ok   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    map_rom_model i_map_rom (.clk(clk), .addr(map_addr), .data(map_data));
    gfx_rom_model i_gfx_rom (.clk(clk), .addr(scr_addr), .req(scr_req),
                             .data(scr_data), .ok(scr_ok));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel enable on every 8th clk
    always @(posedge clk) begin
        cen_div <= cen_div + 3'd1;
        cen6    <= (cen_div == 3'd7);
    end

    // Expected screen position, counted from the pixel enables
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_h <= 0;
            scan_v <= 0;
        end else if (cen6) begin
            if (scan_h == H_TOTAL - 1) begin
                scan_h <= 0;
                scan_v <= (scan_v == V_TOTAL - 1) ? 0 : scan_v + 1;
            end else begin
                scan_h <= scan_h + 1;
            end
        end
    end

    task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at line %0d, H %0d",
                     name, got, exp, scan_v, scan_h);
        end
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        $display("%-16s %5d checks, %0d errors", name, chk_cnt - chk0, err_cnt - err0);
    endtask

    // Returns after the cen6 edge, at the following falling clk edge
    task automatic next_pixel();
        @(posedge clk);
        while (!cen6) @(posedge clk);
        @(negedge clk);
    endtask

    // {pal, pix} of the tile layer at a screen position, by the fetch and flip rules
    function automatic logic [7:0] layer_pixel(input int h, input int v);
        logic [8:0]  px;
        logic [8:0]  py;
        map_attr_t   attr;
        logic [2:0]  r;
        logic [2:0]  k;
        logic [15:0] w;
        px   = 9'(h) + ref_sh;
        py   = 9'(v) + ref_sv;
        attr = i_map_rom.map_word({py[8:3], px[8:3]});
        r    = py[2:0] ^ {3{attr.vflip}};
        k    = attr.hflip ? 3'd7 - px[2:0] : px[2:0];
        w    = i_gfx_rom.gfx_word({attr.code, r, k[2]});
        return {attr.pal, w[{k[1:0], 2'b00} +: 4]};
    endfunction

    task automatic write_palette(input logic [7:0] addr, input logic [11:0] data);
        @(posedge clk);
        pal_wr <= {1'b1, addr, data};
        pal_ref[addr] = data;
    endtask

    task automatic set_scroll(input logic [8:0] sh, input logic [8:0] sv);
        // Active part of a line lies before hinit
        while (!LHBL_dly) next_pixel();
        @(posedge clk);
        scrpos <= {sh, sv};
        ref_sh = sh;
        ref_sv = sv;
    endtask

    // Compares the next full visible line with the model
    task automatic check_line(output int n_clear);
        int       line;
        logic [7:0] raw;
        logic [7:0] idx;
        rgb_t     exp;
        n_clear = 0;
        while (LHBL_dly && LVBL_dly) next_pixel();
        while (!(LHBL_dly && LVBL_dly)) next_pixel();
        line = scan_v;
        check_eq("scan_h at line start", 16'(scan_h), 16'(PIPE_DLY));
        for (int h = 0; h < H_ACTIVE; h++) begin
            if (h != 0) next_pixel();
            raw = layer_pixel(h, line);
            if (raw[3:0] == 4'd0) n_clear++;
            idx = (gfx_en && raw[3:0] != 4'd0) ? raw : 8'd0;
            exp = rgb_t'(pal_ref[idx]);
            check_eq("red", 16'(red), 16'(exp.red));
            check_eq("green", 16'(green), 16'(exp.green));
            check_eq("blue", 16'(blue), 16'(exp.blue));
            check_eq("LHBL_dly", 16'(LHBL_dly), 16'd1);
        end
    endtask

    task automatic reset_state();
        int chk0;
        int err0;
        chk0 = chk_cnt;
        err0 = err_cnt;
        for (int i = 0; i < 10; i++) begin
            // Eight clks in reset, then two pixel periods after release
            if (i < 8) begin
                @(negedge clk);
            end else begin
                next_pixel();
            end
            check_eq("red", 16'(red), 16'd0);
            check_eq("green", 16'(green), 16'd0);
            check_eq("blue", 16'(blue), 16'd0);
            check_eq("LHBL_dly", 16'(LHBL_dly), 16'd0);
            check_eq("LVBL_dly", 16'(LVBL_dly), 16'd0);
            if (i == 7) begin
                @(posedge clk);
                rst_n <= 1'b1;
            end
        end
        report_test("reset", chk0, err0);
    endtask

    task automatic line_timing();
        int chk0;
        int err0;
        int total;
        int high;
        logic prev;
        chk0 = chk_cnt;
        err0 = err_cnt;
        while (LHBL_dly) next_pixel();
        while (!LHBL_dly) next_pixel();
        total = 0;
        high  = 0;
        do begin
            if (LHBL_dly) high++;
            prev = LHBL_dly;
            next_pixel();
            total++;
        end while (!(LHBL_dly && !prev) && total < 2 * H_TOTAL);
        check_eq("LHBL_dly period", 16'(total), 16'(H_TOTAL));
        check_eq("LHBL_dly high time", 16'(high), 16'(H_ACTIVE));
        report_test("line timing", chk0, err0);
    endtask

    task automatic render_line(input string name, input logic [8:0] sh, input logic [8:0] sv);
        int chk0;
        int err0;
        int n_clear;
        chk0 = chk_cnt;
        err0 = err_cnt;
        set_scroll(sh, sv);
        check_line(n_clear);
        report_test(name, chk0, err0);
    endtask

    task automatic backdrop_and_enable();
        int chk0;
        int err0;
        int n_clear;
        chk0 = chk_cnt;
        err0 = err_cnt;
        check_line(n_clear);
        chk_cnt++;
        assert (n_clear > 0) else begin
            err_cnt++;
            $display("No transparent pixel on the checked line, backdrop not exercised");
        end
        // Switch the layer off at the end of the active part of a line
        while (LHBL_dly) next_pixel();
        @(posedge clk);
        gfx_en <= 1'b0;
        check_line(n_clear);
        while (LHBL_dly) next_pixel();
        @(posedge clk);
        gfx_en <= 1'b1;
        report_test("backdrop", chk0, err0);
    endtask

    task automatic palette_rewrite();
        int chk0;
        int err0;
        int n_clear;
        chk0 = chk_cnt;
        err0 = err_cnt;
        while (!LVBL_dly) next_pixel();
        while (LVBL_dly) next_pixel();
        // Vertical blanking starts on the first blank line, after the pipeline delay
        check_eq("LVBL_dly fall line", 16'(scan_v), 16'(V_ACTIVE));
        check_eq("LVBL_dly fall H", 16'(scan_h), 16'(PIPE_DLY));
        // Every entry gets a colour different from its old one
        for (int i = 0; i < 256; i++) begin
            write_palette(8'(i), pal_ref[i] ^ 12'(($urandom % 4095) + 1));
        end
        @(posedge clk);
        pal_wr <= '0;
        check_line(n_clear);
        check_line(n_clear);
        report_test("palette write", chk0, err0);
    endtask

    initial begin
        void'($urandom(32'hf04f057d));
        rst_n    = 1'b0;
        cen6     = 1'b0;
        cen_div  = 3'd0;
        gfx_en   = 1'b1;
        scrpos   = '0;
        pal_wr   = '0;
        ref_sh   = '0;
        ref_sv   = '0;
        chk_cnt  = 0;
        err_cnt  = 0;
        reset_state();
        for (int i = 0; i < 256; i++) begin
            write_palette(8'(i), 12'($urandom));
        end
        @(posedge clk);
        pal_wr <= '0;
        line_timing();
        render_line("unscrolled", 9'd0, 9'd0);
        render_line("scroll", 9'd13, 9'd5);
        backdrop_and_enable();
        palette_rewrite();
        $display("Done: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WDOG_TIME);
        $display("Watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
tora_video_pkg.sv
tora_vtimer.sv
tora_tile_fetch.sv
tora_tile_shifter.sv
tora_colmix.sv
tora_video.sv
tb_tora_rom_model.sv
tb_tora_video.sv

/* Bender.yml */
package:
  name: tora_video

export_include_dirs:
  - .

sources:
  - tora_video_pkg.sv
  - tora_vtimer.sv
  - tora_tile_fetch.sv
  - tora_tile_shifter.sv
  - tora_colmix.sv
  - tora_video.sv
  - target: test
    files:
      - tb_tora_rom_model.sv
      - tb_tora_video.sv
